/* list.f */
source/udp_tx_pkg.sv
source/word_stream_if.sv
source/udp_hdr_if.sv
source/udp_hdr_capture.sv
source/udp_frame_sequencer.sv
source/stream_out_buffer.sv
source/udp_ip_tx.sv
tb/tb_udp_ip_tx.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the udp_ip_tx testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f list.f --top-module tb_udp_ip_tx --Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "Test passed" sim.log && exit 0 || exit 1

/* source/stream_out_buffer.sv */
// output skid buffer
`timescale 1ns/1ns

module stream_out_buffer
    import udp_tx_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    word_stream_if.sink in_s,
    output word_t       out_data,
    output keep_t       out_keep,
    output logic        out_last,
    output logic        out_user,
    output logic        out_valid,
    input  logic        out_ready
);
    typedef struct packed {
        word_t data;
        keep_t keep;
        logic  last;
        logic  user;
    } beat_t;

    beat_t in_beat;
    beat_t out_beat;
    beat_t temp_beat;

    logic ready_reg;
    logic ready_early;
    logic out_valid_next;
    logic temp_valid;
    logic temp_valid_next;
    logic store_in_out;
    logic store_in_temp;
    logic store_temp_out;

    assign in_beat = '{data: in_s.data, keep: in_s.keep, last: in_s.last, user: in_s.user};
    assign in_s.ready = ready_reg;

    // accept next cycle if the output drains or both slots are empty
    assign ready_early = out_ready || (!temp_valid && !out_valid);

    always_comb begin
        out_valid_next = out_valid;
        temp_valid_next = temp_valid;
        store_in_out = 1'b0;
        store_in_temp = 1'b0;
        store_temp_out = 1'b0;

        if (ready_reg) begin
            if (out_ready || !out_valid) begin
                out_valid_next = in_s.valid;
                store_in_out = 1'b1;
            end else begin
                // output stalled, park the word
                temp_valid_next = in_s.valid;
                store_in_temp = 1'b1;
            end
        end else if (out_ready) begin
            out_valid_next = temp_valid;
            temp_valid_next = 1'b0;
            store_temp_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_reg <= 1'b0;
            out_valid <= 1'b0;
            temp_valid <= 1'b0;
        end else begin
            ready_reg <= ready_early;
            out_valid <= out_valid_next;
            temp_valid <= temp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_in_out) begin
            out_beat <= in_beat;
        end else if (store_temp_out) begin
            out_beat <= temp_beat;
        end
        if (store_in_temp) begin
            temp_beat <= in_beat;
        end
    end

    assign out_data = out_beat.data;
    assign out_keep = out_beat.keep;
    assign out_last = out_beat.last;
    assign out_user = out_beat.user;

endmodule

/* source/udp_frame_sequencer.sv */
// udp frame sequencer
`timescale 1ns/1ns

module udp_frame_sequencer
    import udp_tx_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    udp_hdr_if.sink       job,
    word_stream_if.sink   in_s,
    word_stream_if.source out_m,
    output logic          busy,
    output logic          error_early_term
);
    seq_state_t state;
    seq_state_t state_next;

    // payload bytes still owed to the output
    len_t rem;
    len_t rem_next;

    // word that completed the length while input last was still pending
    word_t held_data;
    keep_t held_keep;
    logic  hold_load;

    logic       err_next;
    logic       at_end;
    logic       early;
    logic [3:0] in_cnt;
    logic [3:0] trim_cnt;
    keep_t      trim_keep;

    assign job.job_ready = (state == idle);

    assign at_end = (rem <= bytes_per_word);
    assign in_cnt = keep_to_count(in_s.keep);
    assign trim_cnt = at_end ? rem[3:0] : 4'(bytes_per_word);
    // surplus lanes beyond the declared length are dropped here
    assign trim_keep = in_s.keep & count_to_keep(trim_cnt);
    // input ended with fewer bytes than declared
    assign early = in_s.last && (len_t'(in_cnt) < rem);

    always_comb begin
        state_next = state;
        rem_next = rem;
        hold_load = 1'b0;
        err_next = 1'b0;

        in_s.ready = 1'b0;
        out_m.valid = 1'b0;
        out_m.data = '0;
        out_m.keep = '0;
        out_m.last = 1'b0;
        out_m.user = 1'b0;

        case (state)
            idle: begin
                if (job.job_valid) begin
                    rem_next = job.payload_len;
                    state_next = write_header;
                end
            end

            write_header: begin
                // capture holds udp_word until the next frame is accepted
                out_m.data = job.udp_word;
                out_m.keep = '1;
                if (out_m.ready) begin
                    out_m.valid = 1'b1;
                    state_next = write_payload;
                end
            end

            write_payload: begin
                in_s.ready = out_m.ready;
                out_m.data = in_s.data;
                out_m.keep = trim_keep;
                out_m.last = in_s.last;
                out_m.user = early;

                if (in_s.valid && out_m.ready) begin
                    rem_next = rem - bytes_per_word;
                    if (in_s.last) begin
                        out_m.valid = 1'b1;
                        err_next = early;
                        state_next = idle;
                    end else if (at_end) begin
                        // length reached, wait for input last
                        hold_load = 1'b1;
                        state_next = write_payload_last;
                    end else begin
                        out_m.valid = 1'b1;
                    end
                end
            end

            write_payload_last: begin
                // consume and drop surplus words
                in_s.ready = out_m.ready;
                out_m.data = held_data;
                out_m.keep = held_keep;
                out_m.last = 1'b1;

                if (in_s.valid && out_m.ready && in_s.last) begin
                    out_m.valid = 1'b1;
                    state_next = idle;
                end
            end

            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            busy <= 1'b0;
            error_early_term <= 1'b0;
        end else begin
            state <= state_next;
            busy <= (state_next != idle);
            error_early_term <= err_next;
        end
    end

    always_ff @(posedge clk) begin
        rem <= rem_next;
        if (hold_load) begin
            held_data <= in_s.data;
            held_keep <= trim_keep;
        end
    end

endmodule

/* source/udp_hdr_capture.sv */
// udp header capture
`timescale 1ns/1ns

module udp_hdr_capture
    import udp_tx_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      hdr_valid,
    output logic      hdr_ready,
    input  len_t      udp_src_port,
    input  len_t      udp_dst_port,
    input  len_t      udp_length,
    input  len_t      udp_checksum,
    input  ip_hdr_t   ip_in,
    output ip_hdr_t   ip_out,
    output logic      ip_valid,
    input  logic      ip_ready,
    udp_hdr_if.source job
);
    logic hdr_fire;
    logic job_valid_next;
    logic ip_valid_next;
    logic hdr_ready_next;

    assign hdr_fire = hdr_valid && hdr_ready;

    always_comb begin
        job_valid_next = job.job_valid && !job.job_ready;
        ip_valid_next = ip_valid && !ip_ready;

        if (hdr_fire) begin
            job_valid_next = 1'b1;
            ip_valid_next = 1'b1;
        end

        // sequencer idle and no job pending means the previous frame is done
        hdr_ready_next = !job_valid_next && !ip_valid_next
                         && job.job_ready && !job.job_valid;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_ready <= 1'b0;
            ip_valid <= 1'b0;
            job.job_valid <= 1'b0;
        end else begin
            hdr_ready <= hdr_ready_next;
            ip_valid <= ip_valid_next;
            job.job_valid <= job_valid_next;
        end
    end

    // header fields stay put until the next accepted header
    always_ff @(posedge clk) begin
        if (hdr_fire) begin
            ip_out <= ip_in;
            // total length overrides the incoming field
            ip_out.length <= udp_length + ip_hdr_bytes;

            job.udp_word <= hton_word(udp_src_port, udp_dst_port,
                                      udp_length, udp_checksum);
            job.payload_len <= udp_length - udp_hdr_bytes;
        end
    end

endmodule

/* source/udp_hdr_if.sv */
// frame job handoff
`timescale 1ns/1ns

interface udp_hdr_if
    import udp_tx_pkg::*;
();
    logic  job_valid;
    logic  job_ready;
    word_t udp_word;
    len_t  payload_len;

    modport source (
        output job_valid, udp_word, payload_len,
        input  job_ready
    );

    modport sink (
        input  job_valid, udp_word, payload_len,
        output job_ready
    );
endinterface

/* source/udp_ip_tx.sv */
// udp to ip frame transmitter
`timescale 1ns/1ns

module udp_ip_tx
    import udp_tx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       s_udp_hdr_valid,
    output logic       s_udp_hdr_ready,
    input  len_t       s_udp_src_port,
    input  len_t       s_udp_dst_port,
    input  len_t       s_udp_length,
    input  len_t       s_udp_checksum,
    input  len_t       s_ip_identification,
    input  logic [7:0] s_ip_ttl,
    input  logic [7:0] s_ip_protocol,
    input  ip_addr_t   s_ip_src,
    input  ip_addr_t   s_ip_dst,

    input  word_t      s_payload_data,
    input  keep_t      s_payload_keep,
    input  logic       s_payload_valid,
    output logic       s_payload_ready,
    input  logic       s_payload_last,

    output logic       m_ip_hdr_valid,
    input  logic       m_ip_hdr_ready,
    output len_t       m_ip_length,
    output len_t       m_ip_identification,
    output logic [7:0] m_ip_ttl,
    output logic [7:0] m_ip_protocol,
    output ip_addr_t   m_ip_src,
    output ip_addr_t   m_ip_dst,

    output word_t      m_ip_payload_data,
    output keep_t      m_ip_payload_keep,
    output logic       m_ip_payload_valid,
    input  logic       m_ip_payload_ready,
    output logic       m_ip_payload_last,
    output logic       m_ip_payload_user,

    output logic       busy,
    output logic       error_early_term
);
    ip_hdr_t ip_in;
    ip_hdr_t ip_out;

    word_stream_if pay_in ();
    word_stream_if seq_to_buf ();
    udp_hdr_if     job_if ();

    // length is computed in the capture stage
    assign ip_in = '{identification: s_ip_identification, ttl: s_ip_ttl,
                     protocol: s_ip_protocol, src: s_ip_src, dst: s_ip_dst,
                     length: '0};

    assign pay_in.data = s_payload_data;
    assign pay_in.keep = s_payload_keep;
    assign pay_in.last = s_payload_last;
    assign pay_in.user = 1'b0;
    assign pay_in.valid = s_payload_valid;
    assign s_payload_ready = pay_in.ready;

    udp_hdr_capture u_capture (
        .clk          (clk),
        .rst          (rst),
        .hdr_valid    (s_udp_hdr_valid),
        .hdr_ready    (s_udp_hdr_ready),
        .udp_src_port (s_udp_src_port),
        .udp_dst_port (s_udp_dst_port),
        .udp_length   (s_udp_length),
        .udp_checksum (s_udp_checksum),
        .ip_in        (ip_in),
        .ip_out       (ip_out),
        .ip_valid     (m_ip_hdr_valid),
        .ip_ready     (m_ip_hdr_ready),
        .job          (job_if.source)
    );

    udp_frame_sequencer u_sequencer (
        .clk              (clk),
        .rst              (rst),
        .job              (job_if.sink),
        .in_s             (pay_in.sink),
        .out_m            (seq_to_buf.source),
        .busy             (busy),
        .error_early_term (error_early_term)
    );

    stream_out_buffer u_out_buf (
        .clk       (clk),
        .rst       (rst),
        .in_s      (seq_to_buf.sink),
        .out_data  (m_ip_payload_data),
        .out_keep  (m_ip_payload_keep),
        .out_last  (m_ip_payload_last),
        .out_user  (m_ip_payload_user),
        .out_valid (m_ip_payload_valid),
        .out_ready (m_ip_payload_ready)
    );

    assign m_ip_length = ip_out.length;
    assign m_ip_identification = ip_out.identification;
    assign m_ip_ttl = ip_out.ttl;
    assign m_ip_protocol = ip_out.protocol;
    assign m_ip_src = ip_out.src;
    assign m_ip_dst = ip_out.dst;

endmodule

/* source/udp_tx_pkg.sv */
// udp transmitter shared definitions

package udp_tx_pkg;

    // datapath geometry
    localparam int data_w = 64;
    localparam int keep_w = data_w / 8;

    typedef logic [data_w-1:0] word_t;
    typedef logic [keep_w-1:0] keep_t;
    typedef logic [15:0]       len_t;
    typedef logic [31:0]       ip_addr_t;

    // byte counts used for length arithmetic
    localparam len_t bytes_per_word = 16'd8;
    localparam len_t udp_hdr_bytes  = 16'd8;
    localparam len_t ip_hdr_bytes   = 16'd20;

    // kept ip header fields
    typedef struct packed {
        len_t       identification;
        logic [7:0] ttl;
        logic [7:0] protocol;
        ip_addr_t   src;
        ip_addr_t   dst;
        len_t       length;
    } ip_hdr_t;

    typedef enum logic [1:0] {
        idle,
        write_header,
        write_payload,
        write_payload_last
    } seq_state_t;

    // highest set lane plus one, valid for contiguous keep
    function automatic logic [3:0] keep_to_count(keep_t k);
        logic [3:0] n;
        n = 4'd0;
        for (int i = 0; i < keep_w; i++) begin
            if (k[i]) begin
                n = 4'(i + 1);
            end
        end
        return n;
    endfunction

    function automatic keep_t count_to_keep(logic [3:0] c);
        return keep_t'((9'd1 << c) - 9'd1);
    endfunction

    // byte 0 sits in bits 7:0 and carries the msb of the source port
    function automatic word_t hton_word(len_t src, len_t dst, len_t len, len_t csum);
        return {csum[7:0], csum[15:8], len[7:0], len[15:8],
                dst[7:0], dst[15:8], src[7:0], src[15:8]};
    endfunction

endpackage

/* source/word_stream_if.sv */
// 64-bit word stream
`timescale 1ns/1ns

interface word_stream_if
    import udp_tx_pkg::*;
();
    word_t data;
    keep_t keep;
    logic  last;
    logic  user;
    logic  valid;
    logic  ready;

    // word moves on an edge with valid and ready both high
    modport source (
        output data, keep, last, user, valid,
        input  ready
    );

    modport sink (
        input  data, keep, last, user, valid,
        output ready
    );
endinterface

/* tb/tb_udp_ip_tx.sv */
// udp to ip transmitter testbench
`timescale 1ns/1ns

module tb_udp_ip_tx
    import udp_tx_pkg::*;
();
    // six tests of under 400 cycles each, plus margin for reset
    localparam int cycle_limit = 400 * 10;

    typedef struct packed {
        word_t data;
        keep_t keep;
        logic  last;
        logic  user;
    } beat_t;

    logic clk;
    logic rst;
    logic s_udp_hdr_valid;
    logic s_udp_hdr_ready;
    len_t s_udp_src_port;
    len_t s_udp_dst_port;
    len_t s_udp_length;
    len_t s_udp_checksum;
    len_t s_ip_identification;
    logic [7:0] s_ip_ttl;
    logic [7:0] s_ip_protocol;
    ip_addr_t s_ip_src;
    ip_addr_t s_ip_dst;
    word_t s_payload_data;
    keep_t s_payload_keep;
    logic s_payload_valid;
    logic s_payload_ready;
    logic s_payload_last;
    logic m_ip_hdr_valid;
    logic m_ip_hdr_ready;
    len_t m_ip_length;
    len_t m_ip_identification;
    logic [7:0] m_ip_ttl;
    logic [7:0] m_ip_protocol;
    ip_addr_t m_ip_src;
    ip_addr_t m_ip_dst;
    word_t m_ip_payload_data;
    keep_t m_ip_payload_keep;
    logic m_ip_payload_valid;
    logic m_ip_payload_ready;
    logic m_ip_payload_last;
    logic m_ip_payload_user;
    logic busy;
    logic error_early_term;

    logic [31:0] lfsr = 32'ha23a_15ae;
    logic hdr_hold = 1'b0;
    logic sink_rand = 1'b0;
    int cycles = 0;
    int checks = 0;
    int errors = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_bad = 0;
    int frames_exp = 0;
    int frames_out = 0;
    int err_cycles = 0;
    int err_base = 0;
    int exp_pulses = 0;

    beat_t exp_q[$];
    beat_t act_q[$];
    ip_hdr_t exp_hdr[$];
    ip_hdr_t act_hdr[$];

    udp_ip_tx dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic word_t lfsr_word(int n);
        word_t w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w = {w[62:0], lfsr_step()};
        end
        return w;
    endfunction

    // wire byte i goes to bits 8*i+7:8*i, high byte of each field first
    function automatic word_t net_order(len_t src, len_t dst, len_t len, len_t csum);
        logic [7:0] b [8];
        word_t w;
        b = '{src[15:8], src[7:0], dst[15:8], dst[7:0],
              len[15:8], len[7:0], csum[15:8], csum[7:0]};
        for (int i = 0; i < 8; i++) begin
            w[8*i +: 8] = b[i];
        end
        return w;
    endfunction

    function automatic keep_t lanes(int n);
        keep_t k;
        k = '0;
        for (int i = 0; i < n; i++) begin
            k[i] = 1'b1;
        end
        return k;
    endfunction

    function automatic int level_of(logic v);
        if (v === 1'b1) begin
            return 1;
        end
        if (v === 1'b0) begin
            return 0;
        end
        return -1;
    endfunction

    function automatic ip_hdr_t live_hdr();
        return ip_hdr_t'{identification: m_ip_identification, ttl: m_ip_ttl,
                         protocol: m_ip_protocol, src: m_ip_src, dst: m_ip_dst,
                         length: m_ip_length};
    endfunction

    // sink side handshakes
    initial begin
        m_ip_payload_ready = 1'b0;
        m_ip_hdr_ready = 1'b0;
        forever begin
            @(negedge clk);
            m_ip_payload_ready = sink_rand ? lfsr_step() : 1'b1;
            m_ip_hdr_ready = hdr_hold ? 1'b0 : (sink_rand ? lfsr_step() : 1'b1);
        end
    end

    always @(posedge clk) begin
        if (m_ip_payload_valid && m_ip_payload_ready) begin
            act_q.push_back(beat_t'{m_ip_payload_data, m_ip_payload_keep,
                                    m_ip_payload_last, m_ip_payload_user});
            if (m_ip_payload_last) begin
                frames_out++;
            end
        end
        if (m_ip_hdr_valid && m_ip_hdr_ready) begin
            act_hdr.push_back(live_hdr());
        end
        if (error_early_term) begin
            err_cycles++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    task automatic compare_hdr(string name, ip_hdr_t exp, ip_hdr_t act);
        checks++;
        if (act !== exp) begin
            $display("Fail %s: ip header expected %h actual %h", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic compare_word(string name, int idx, word_t ed, keep_t ek, logic el,
                                logic eu, word_t ad, keep_t ak, logic al, logic au);
        checks++;
        if (ad !== ed || ak !== ek || al !== el || au !== eu) begin
            $display("Fail %s word %0d: expected %h/%h/%b/%b actual %h/%h/%b/%b",
                     name, idx, ed, ek, el, eu, ad, ak, al, au);
            errors++;
            test_errors++;
        end
    endtask

    task automatic compare_flag(string name, string what, int exp, int act);
        checks++;
        if (act != exp) begin
            $display("Fail %s: %s expected %0d actual %0d", name, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_test(string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d mismatches", name, test_errors);
            tests_bad++;
        end
        test_errors = 0;
    endtask

    // sends one frame and queues what the output must show
    task automatic run_frame(string name, len_t udp_len, int in_bytes, logic gaps, int hold);
        ip_hdr_t hdr;
        len_t src;
        len_t dst;
        len_t csum;
        word_t data[$];
        int n_in;
        int rem;
        int cnt;
        int take;
        logic last_out;
        src = len_t'(lfsr_word(16));
        dst = len_t'(lfsr_word(16));
        csum = len_t'(lfsr_word(16));
        hdr = ip_hdr_t'{identification: len_t'(lfsr_word(16)), ttl: 8'(lfsr_word(8)),
                        protocol: 8'(lfsr_word(8)), src: 32'(lfsr_word(32)),
                        dst: 32'(lfsr_word(32)), length: len_t'(udp_len + 16'd20)};
        n_in = (in_bytes + 7) / 8;
        for (int j = 0; j < n_in; j++) begin
            data.push_back(lfsr_word(64));
        end

        exp_hdr.push_back(hdr);
        exp_q.push_back(beat_t'{net_order(src, dst, udp_len, csum), 8'hff, 1'b0, 1'b0});
        rem = int'(udp_len) - 8;
        for (int j = 0; j < n_in; j++) begin
            cnt = (j == n_in - 1) ? in_bytes - 8 * j : 8;
            take = (cnt < rem) ? cnt : rem;
            last_out = (rem <= 8) || (j == n_in - 1);
            exp_q.push_back(beat_t'{data[j], lanes(take), last_out,
                                    (j == n_in - 1) && (cnt < rem)});
            if (j == n_in - 1 && cnt < rem) begin
                exp_pulses++;
            end
            if (last_out) begin
                break;
            end
            rem -= 8;
        end
        frames_exp++;

        s_udp_hdr_valid = 1'b1;
        s_udp_src_port = src;
        s_udp_dst_port = dst;
        s_udp_length = udp_len;
        s_udp_checksum = csum;
        s_ip_identification = hdr.identification;
        s_ip_ttl = hdr.ttl;
        s_ip_protocol = hdr.protocol;
        s_ip_src = hdr.src;
        s_ip_dst = hdr.dst;
        while (!s_udp_hdr_ready) @(negedge clk);
        @(negedge clk);
        s_udp_hdr_valid = 1'b0;

        // ip header must wait, unchanged, while the sink holds off
        if (hold > 0) begin
            compare_flag(name, "ip header valid", 1, level_of(m_ip_hdr_valid));
            repeat (hold) begin
                compare_hdr(name, hdr, live_hdr());
                @(negedge clk);
            end
            compare_flag(name, "ip header valid", 1, level_of(m_ip_hdr_valid));
            hdr_hold = 1'b0;
        end

        for (int j = 0; j < n_in; j++) begin
            while (gaps && (lfsr_step() & lfsr_step())) begin
                s_payload_valid = 1'b0;
                @(negedge clk);
            end
            s_payload_valid = 1'b1;
            s_payload_data = data[j];
            s_payload_keep = lanes((j == n_in - 1) ? in_bytes - 8 * j : 8);
            s_payload_last = (j == n_in - 1);
            while (!s_payload_ready) @(negedge clk);
            // payload ready only shows while a frame is in flight
            compare_flag(name, "busy during payload", 1, level_of(busy));
            @(negedge clk);
        end
        s_payload_valid = 1'b0;
        s_payload_last = 1'b0;
    endtask

    task automatic finish_test(string name);
        beat_t e;
        beat_t a;
        int idx;
        while (frames_out < frames_exp || act_hdr.size() < exp_hdr.size()) @(negedge clk);
        repeat (3) @(negedge clk);
        if (act_q.size() != exp_q.size()) begin
            $display("%s: output had %0d words where %0d were expected",
                     name, act_q.size(), exp_q.size());
            errors++;
            test_errors++;
        end
        idx = 0;
        while (exp_q.size() > 0 && act_q.size() > 0) begin
            e = exp_q.pop_front();
            a = act_q.pop_front();
            compare_word(name, idx, e.data, e.keep, e.last, e.user,
                         a.data, a.keep, a.last, a.user);
            idx++;
        end
        while (exp_hdr.size() > 0 && act_hdr.size() > 0) begin
            compare_hdr(name, exp_hdr.pop_front(), act_hdr.pop_front());
        end
        if (act_hdr.size() != 0) begin
            $display("%s: more ip headers came out than were sent", name);
            errors++;
            test_errors++;
        end
        compare_flag(name, "error pulse cycles", exp_pulses, err_cycles - err_base);
        compare_flag(name, "busy when done", 0, level_of(busy));
        exp_q.delete();
        act_q.delete();
        exp_hdr.delete();
        act_hdr.delete();
        err_base = err_cycles;
        exp_pulses = 0;
        report_test(name);
    endtask

    task automatic test_reset();
        compare_flag("reset", "ip header valid", 0, level_of(m_ip_hdr_valid));
        compare_flag("reset", "payload valid", 0, level_of(m_ip_payload_valid));
        compare_flag("reset", "busy", 0, level_of(busy));
        compare_flag("reset", "error flag", 0, level_of(error_early_term));
        compare_flag("reset", "payload ready", 0, level_of(s_payload_ready));
        compare_flag("reset", "header ready", 0, level_of(s_udp_hdr_ready));
        @(negedge clk);
        compare_flag("reset", "header ready", 1, level_of(s_udp_hdr_ready));
        report_test("reset");
    endtask

    task automatic test_header();
        hdr_hold = 1'b1;
        @(negedge clk);
        run_frame("header_fields", 16'd16, 8, 1'b0, 3);
        finish_test("header_fields");
    endtask

    task automatic test_exact();
        // 19 payload bytes, last word keeps 3 lanes
        run_frame("exact_length", 16'd27, 19, 1'b0, 0);
        finish_test("exact_length");
    endtask

    task automatic test_surplus();
        run_frame("surplus_words", 16'd20, 32, 1'b0, 0);
        finish_test("surplus_words");
    endtask

    task automatic test_early();
        run_frame("early_term", 16'd40, 13, 1'b0, 0);
        finish_test("early_term");
    endtask

    task automatic test_back_to_back();
        len_t len_a;
        len_t len_b;
        len_t len_c;
        len_a = 16'd9 + len_t'(lfsr_word(6));
        len_b = 16'd9 + len_t'(lfsr_word(6));
        len_c = 16'd17 + len_t'(lfsr_word(5));
        sink_rand = 1'b1;
        run_frame("back_to_back", len_a, int'(len_a) - 8, 1'b1, 0);
        run_frame("back_to_back", len_b, int'(len_b) - 7 + int'(lfsr_word(4)), 1'b1, 0);
        run_frame("back_to_back", len_c, int'(len_c) - 9 - int'(lfsr_word(3)), 1'b1, 0);
        finish_test("back_to_back");
        sink_rand = 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        s_udp_hdr_valid = 1'b0;
        s_udp_src_port = '0;
        s_udp_dst_port = '0;
        s_udp_length = '0;
        s_udp_checksum = '0;
        s_ip_identification = '0;
        s_ip_ttl = '0;
        s_ip_protocol = '0;
        s_ip_src = '0;
        s_ip_dst = '0;
        s_payload_data = '0;
        s_payload_keep = '0;
        s_payload_valid = 1'b0;
        s_payload_last = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        test_reset();
        test_header();
        test_exact();
        test_surplus();
        test_early();
        test_back_to_back();

        $display("tests %0d, tests with errors %0d, checks %0d, mismatches %0d",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
